// File: alu_decode_stage.sv
`default_nettype none
`include "alu_params.svh"

// First pipeline stage.
// Checks the instruction class and buffers one item.
module alu_decode_stage (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    in_req,
  output logic                   in_ack,
  input  var  alu_pkg::instr_u   instr,
  input  wire [`ALU_WIDTH-1:0]   b,
  input  wire [`ALU_WIDTH-1:0]   c,
  output logic                   d_req,
  input  wire                    d_ack,
  output alu_pkg::alu_func_e     d_func,
  output logic                   d_dest,
  output logic                   d_err,
  output logic [`ALU_WIDTH-1:0]  d_b,
  output logic [`ALU_WIDTH-1:0]  d_c
);

  // MOV8 words carry 00 in the top two bits.
  localparam logic [1:0] MOVE_CLASS = 2'b00;

  logic full;
  logic sent;
  logic capture;
  logic is_alu;
  logic is_move;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Class check.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign is_alu  = (instr.alu.cls == `ALU_CLASS);
  assign is_move = (instr.mov.cls == MOVE_CLASS);

  // New item while idle and not already acknowledging.
  assign capture = in_req && !in_ack && !full;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Handshake control.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset) begin
      in_ack <= 1'b0;
      d_req  <= 1'b0;
      full   <= 1'b0;
      sent   <= 1'b0;
    end else begin
      // Input side, ack on capture, drop after req goes away.
      if (capture) begin
        in_ack <= 1'b1;
        full   <= 1'b1;
      end else if (in_ack && !in_req) begin
        in_ack <= 1'b0;
      end
      // Output side, req one cycle after capture.
      if (full && !d_req && !sent) begin
        d_req <= 1'b1;
      end else if (d_req && d_ack) begin
        d_req <= 1'b0;
        sent  <= 1'b1;
      end
      // Buffer frees once the next stage has dropped ack.
      if (sent && !d_ack) begin
        full <= 1'b0;
        sent <= 1'b0;
      end
    end
  end

  // Item buffer.
  always_ff @(posedge clk) begin
    if (capture) begin
      d_func <= instr.alu.func;
      d_dest <= instr.alu.dest;
      d_err  <= is_move || !is_alu;
      d_b    <= b;
      d_c    <= c;
    end
  end

  // Sender holds req and the byte until it sees ack.
  a_instr_stable : assert property (@(posedge clk) disable iff (reset)
    (in_req && !in_ack) |=> in_ack || (in_req && $stable(instr)));

endmodule

`default_nettype wire

// File: alu_execute_stage.sv
`default_nettype none
`include "alu_params.svh"

// Second pipeline stage.
// Computes result and carry for the buffered function.
module alu_execute_stage (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    d_req,
  output logic                   d_ack,
  input  var  alu_pkg::alu_func_e d_func,
  input  wire                    d_dest,
  input  wire                    d_err,
  input  wire [`ALU_WIDTH-1:0]   d_b,
  input  wire [`ALU_WIDTH-1:0]   d_c,
  output logic                   e_req,
  input  wire                    e_ack,
  output logic [`ALU_WIDTH-1:0]  e_result,
  output logic                   e_carry,
  output logic                   e_dest,
  output logic                   e_err
);

  logic full;
  logic sent;
  logic capture;
  logic [`ALU_WIDTH-1:0] logic_out;
  // Carry sits in the top bit of both sums.
  logic [`ALU_WIDTH:0]   add_sum;
  logic [`ALU_WIDTH:0]   inc_sum;
  logic [`ALU_WIDTH-1:0] next_result;
  logic                  next_carry;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Datapath.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  alu_logic_unit u_logic (
    .b         (d_b),
    .c         (d_c),
    .func      (d_func),
    .logic_out (logic_out)
  );

  assign add_sum = {1'b0, d_b} + {1'b0, d_c};
  assign inc_sum = {1'b0, d_b} + {{`ALU_WIDTH{1'b0}}, 1'b1};

  always_comb begin
    next_result = '0;
    next_carry  = 1'b0;
    // Rejected words produce nothing.
    if (!d_err) begin
      case (d_func)
        alu_pkg::FN_ADD: {next_carry, next_result} = add_sum;
        alu_pkg::FN_INC: {next_carry, next_result} = inc_sum;
        // Rotate left. The old top bit also goes to carry.
        alu_pkg::FN_SHL: begin
          next_result = {d_b[`ALU_WIDTH-2:0], d_b[`ALU_WIDTH-1]};
          next_carry  = d_b[`ALU_WIDTH-1];
        end
        alu_pkg::FN_CLR: next_result = '0;
        default:         next_result = logic_out;
      endcase
    end
  end

  assign capture = d_req && !d_ack && !full;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Handshake control.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset) begin
      d_ack <= 1'b0;
      e_req <= 1'b0;
      full  <= 1'b0;
      sent  <= 1'b0;
    end else begin
      if (capture) begin
        d_ack <= 1'b1;
        full  <= 1'b1;
      end else if (d_ack && !d_req) begin
        d_ack <= 1'b0;
      end
      if (full && !e_req && !sent) begin
        e_req <= 1'b1;
      end else if (e_req && e_ack) begin
        e_req <= 1'b0;
        sent  <= 1'b1;
      end
      // Free again after the flags stage lowers ack.
      if (sent && !e_ack) begin
        full <= 1'b0;
        sent <= 1'b0;
      end
    end
  end

  // Result buffer loaded from the combinational datapath.
  always_ff @(posedge clk) begin
    if (capture) begin
      e_result <= next_result;
      e_carry  <= next_carry;
      e_dest   <= d_dest;
      e_err    <= d_err;
    end
  end

  // Decode holds its item steady until this stage acknowledges.
  a_in_stable : assert property (@(posedge clk) disable iff (reset)
    (d_req && !d_ack) |=> d_ack || (d_req && $stable({d_func, d_dest, d_err, d_b, d_c})));

endmodule

`default_nettype wire

// File: alu_flags_stage.sv
`default_nettype none
`include "alu_params.svh"

// Last pipeline stage.
// Adds zero and sign and drives the output link.
module alu_flags_stage (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    e_req,
  output logic                   e_ack,
  input  wire [`ALU_WIDTH-1:0]   e_result,
  input  wire                    e_carry,
  input  wire                    e_dest,
  input  wire                    e_err,
  output logic                   out_req,
  input  wire                    out_ack,
  output logic [`ALU_WIDTH-1:0]  result,
  output logic                   carry,
  output logic                   zero,
  output logic                   sign,
  output logic                   dest,
  output logic                   err
);

  logic full;
  logic sent;
  logic capture;

  assign capture = e_req && !e_ack && !full;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Handshake control.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset) begin
      e_ack   <= 1'b0;
      out_req <= 1'b0;
      full    <= 1'b0;
      sent    <= 1'b0;
    end else begin
      if (capture) begin
        e_ack <= 1'b1;
        full  <= 1'b1;
      end else if (e_ack && !e_req) begin
        e_ack <= 1'b0;
      end
      if (full && !out_req && !sent) begin
        out_req <= 1'b1;
      end else if (out_req && out_ack) begin
        out_req <= 1'b0;
        sent    <= 1'b1;
      end
      if (sent && !out_ack) begin
        full <= 1'b0;
        sent <= 1'b0;
      end
    end
  end

  // Output registers with flags taken from the incoming result.
  always_ff @(posedge clk) begin
    if (capture) begin
      result <= e_result;
      carry  <= e_carry;
      zero   <= (e_result == '0);
      sign   <= e_result[`ALU_WIDTH-1];
      dest   <= e_dest;
      err    <= e_err;
    end
  end

  // Execute holds its result steady until this stage acknowledges.
  a_in_stable : assert property (@(posedge clk) disable iff (reset)
    (e_req && !e_ack) |=> e_ack || (e_req && $stable({e_result, e_carry, e_dest, e_err})));

endmodule

`default_nettype wire

// File: alu_logic_unit.sv
`default_nettype none
`include "alu_params.svh"

// Bitwise part of the ALU.
// Each bit forms all four logic results at once, the function picks one.
module alu_logic_unit (
  input  wire [`ALU_WIDTH-1:0] b,
  input  wire [`ALU_WIDTH-1:0] c,
  input  var  alu_pkg::alu_func_e func,
  output logic [`ALU_WIDTH-1:0] logic_out
);

  // Per-bit results, one vector per operation.
  logic [`ALU_WIDTH-1:0] and_bits;
  logic [`ALU_WIDTH-1:0] or_bits;
  logic [`ALU_WIDTH-1:0] xor_bits;
  logic [`ALU_WIDTH-1:0] not_bits;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // One-bit logic blocks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar i = 0; i < `ALU_WIDTH; i++) begin : g_bit
    // Same four outputs as the one-bit relay block.
    assign and_bits[i] = b[i] & c[i];
    assign or_bits[i]  = b[i] | c[i];
    assign xor_bits[i] = b[i] ^ c[i];
    // NOT only looks at b.
    assign not_bits[i] = ~b[i];
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Function select.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    case (func)
      alu_pkg::FN_AND: logic_out = and_bits;
      alu_pkg::FN_OR:  logic_out = or_bits;
      alu_pkg::FN_XOR: logic_out = xor_bits;
      alu_pkg::FN_NOT: logic_out = not_bits;
      // Arithmetic, shift and clear come from elsewhere.
      default:         logic_out = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: alu_params.svh
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU sizing.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Width of the b and c registers and of the result.
`define ALU_WIDTH 8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction classes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Upper nibble of an ALU instruction byte, 1000rfff.
`define ALU_CLASS 4'b1000

`endif

// File: alu_pkg.sv
`default_nettype none

package alu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ALU function codes.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Low three bits of the instruction byte select the function.
  typedef enum logic [2:0] {
    FN_ADD = 3'd0,
    FN_INC = 3'd1,
    FN_AND = 3'd2,
    FN_OR  = 3'd3,
    FN_XOR = 3'd4,
    FN_NOT = 3'd5,
    FN_SHL = 3'd6,
    FN_CLR = 3'd7
  } alu_func_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction byte views.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // ALU view, 1000rfff.
  // The r bit picks the destination register, A or D.
  typedef struct packed {
    logic [3:0] cls;
    logic       dest;
    alu_func_e  func;
  } alu_view_t;

  // Register move view, 00dddsss.
  typedef struct packed {
    logic [1:0] cls;
    logic [2:0] dst_reg;
    logic [2:0] src_reg;
  } move_view_t;

  // One byte, read either way by the decoder.
  typedef union packed {
    alu_view_t  alu;
    move_view_t mov;
  } instr_u;

endpackage

`default_nettype wire

// File: flist.f
+incdir+.
alu_pkg.sv
alu_logic_unit.sv
alu_decode_stage.sv
alu_execute_stage.sv
alu_flags_stage.sv
relay_alu_top.sv
tb_relay_alu.sv

// File: relay_alu_top.sv
`default_nettype none
`include "alu_params.svh"

// ALU pipeline, decode then execute then flags.
module relay_alu_top (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    in_req,
  output logic                   in_ack,
  input  var  alu_pkg::instr_u   instr,
  input  wire [`ALU_WIDTH-1:0]   b,
  input  wire [`ALU_WIDTH-1:0]   c,
  output logic                   out_req,
  input  wire                    out_ack,
  output logic [`ALU_WIDTH-1:0]  result,
  output logic                   carry,
  output logic                   zero,
  output logic                   sign,
  output logic                   dest,
  output logic                   err
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage links.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Decode to execute.
  logic                  d_req;
  logic                  d_ack;
  alu_pkg::alu_func_e    d_func;
  logic                  d_dest;
  logic                  d_err;
  logic [`ALU_WIDTH-1:0] d_b;
  logic [`ALU_WIDTH-1:0] d_c;
  // Execute to flags.
  logic                  e_req;
  logic                  e_ack;
  logic [`ALU_WIDTH-1:0] e_result;
  logic                  e_carry;
  logic                  e_dest;
  logic                  e_err;

  alu_decode_stage u_decode (
    .clk, .reset, .in_req, .in_ack, .instr, .b, .c,
    .d_req, .d_ack, .d_func, .d_dest, .d_err, .d_b, .d_c
  );

  alu_execute_stage u_execute (
    .clk, .reset, .d_req, .d_ack, .d_func, .d_dest, .d_err, .d_b, .d_c,
    .e_req, .e_ack, .e_result, .e_carry, .e_dest, .e_err
  );

  alu_flags_stage u_flags (
    .clk, .reset, .e_req, .e_ack, .e_result, .e_carry, .e_dest, .e_err,
    .out_req, .out_ack, .result, .carry, .zero, .sign, .dest, .err
  );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the relay ALU testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_relay_alu -f flist.f -o sim_relay_alu

# The simulator exits non-zero on $fatal, the log decides the outcome.
./obj_dir/sim_relay_alu > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
  echo "Simulation ended without a verdict"
  exit 1
fi

// File: tb_relay_alu.sv
`default_nettype none
`include "alu_params.svh"

// Directed testbench for the three-stage relay ALU.
module tb_relay_alu;
  timeunit 1ns;
  timeprecision 100ps;

  // Cycles a single wait may take.
  localparam int TIMEOUT = 100;

  logic                  clk;
  logic                  reset;
  logic                  in_req;
  logic                  in_ack;
  alu_pkg::instr_u       instr;
  logic [`ALU_WIDTH-1:0] b;
  logic [`ALU_WIDTH-1:0] c;
  logic                  out_req;
  logic                  out_ack;
  logic [`ALU_WIDTH-1:0] result;
  logic                  carry;
  logic                  zero;
  logic                  sign;
  logic                  dest;
  logic                  err;

  integer seed = 54;

  // Expected {result, carry, zero, sign, dest, err} in issue order.
  logic [12:0] exp_q[$];
  logic [7:0]  word_q[$];

  relay_alu_top dut (
    .clk, .reset, .in_req, .in_ack, .instr, .b, .c,
    .out_req, .out_ack, .result, .carry, .zero, .sign, .dest, .err
  );

  always #10 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model and checks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [12:0] model(input logic [7:0] word, input logic [7:0] op_b,
                                        input logic [7:0] op_c);
    logic [8:0] wide;
    logic       bad;
    wide = 9'd0;
    // Anything outside class 1000 is rejected. Move words are too.
    bad = (word[7:4] != `ALU_CLASS);
    if (!bad) begin
      case (word[2:0])
        alu_pkg::FN_ADD: wide = {1'b0, op_b} + {1'b0, op_c};
        alu_pkg::FN_INC: wide = {1'b0, op_b} + 9'd1;
        alu_pkg::FN_AND: wide = {1'b0, op_b & op_c};
        alu_pkg::FN_OR:  wide = {1'b0, op_b | op_c};
        alu_pkg::FN_XOR: wide = {1'b0, op_b ^ op_c};
        alu_pkg::FN_NOT: wide = {1'b0, ~op_b};
        // Carry gets the bit that leaves the top.
        alu_pkg::FN_SHL: wide = {op_b[7], op_b[6:0], op_b[7]};
        default:         wide = 9'd0;
      endcase
    end
    return {wide[7:0], wide[8], wide[7:0] == 8'd0, wide[7], word[3], bad};
  endfunction

  task automatic stop_with_error(input string why);
    $display("Error at %0d ns: %s", $time, why);
    $display("Result: FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input logic [7:0] got, input logic [7:0] want, input string what);
    if (got !== want) begin
      $display("Mismatch at %0d ns: %s, got %h, expected %h", $time, what, got, want);
      $display("Result: FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // Inputs change 2 ns after the rising edge.
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Handshake tasks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic send(input logic [7:0] word, input logic [7:0] op_b, input logic [7:0] op_c);
    int waited;
    exp_q.push_back(model(word, op_b, op_c));
    word_q.push_back(word);
    instr  = word;
    b      = op_b;
    c      = op_c;
    in_req = 1'b1;
    waited = 0;
    while (!in_ack) begin
      next_cycle();
      waited++;
      if (waited > TIMEOUT) stop_with_error("timeout waiting for in_ack to rise");
    end
    in_req = 1'b0;
    waited = 0;
    while (in_ack) begin
      next_cycle();
      waited++;
      if (waited > TIMEOUT) stop_with_error("timeout waiting for in_ack to fall");
    end
  endtask

  task automatic receive(input int delay);
    int          waited;
    logic [12:0] want;
    string       tag;
    waited = 0;
    while (!out_req) begin
      next_cycle();
      waited++;
      if (waited > TIMEOUT) stop_with_error("timeout waiting for out_req to rise");
    end
    // Optional stall before taking the item.
    repeat (delay) next_cycle();
    if (exp_q.size() == 0) stop_with_error("DUT produced an item that was never sent");
    want = exp_q.pop_front();
    tag  = $sformatf("instr %h", word_q.pop_front());
    check(result, want[12:5], {tag, " result"});
    check(8'(carry), 8'(want[4]), {tag, " carry"});
    check(8'(zero), 8'(want[3]), {tag, " zero"});
    check(8'(sign), 8'(want[2]), {tag, " sign"});
    check(8'(dest), 8'(want[1]), {tag, " dest"});
    check(8'(err), 8'(want[0]), {tag, " err"});
    out_ack = 1'b1;
    waited  = 0;
    while (out_req) begin
      next_cycle();
      waited++;
      if (waited > TIMEOUT) stop_with_error("timeout waiting for out_req to fall");
    end
    out_ack = 1'b0;
  endtask

  task automatic run_item(input logic [7:0] word, input logic [7:0] op_b,
                          input logic [7:0] op_c, input int delay);
    send(word, op_b, op_c);
    receive(delay);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_idle_after_reset();
    check(8'(in_ack), 8'd0, "in_ack after reset");
    check(8'(out_req), 8'd0, "out_req after reset");
  endtask

  task automatic run_all_functions();
    run_item(8'h80, 8'hFF, 8'h01, 0);
    run_item(8'h80, 8'h3C, 8'h41, 1);
    run_item(8'h81, 8'hFF, 8'h00, 0);
    run_item(8'h89, 8'h7F, 8'h00, 0);
    run_item(8'h82, 8'hA5, 8'h3C, 0);
    run_item(8'h83, 8'hA5, 8'h3C, 2);
    run_item(8'h8C, 8'hA5, 8'h3C, 0);
    run_item(8'h85, 8'h0F, 8'hFF, 0);
    run_item(8'h86, 8'h81, 8'h00, 0);
    run_item(8'h8E, 8'h40, 8'h00, 3);
    run_item(8'h87, 8'hFF, 8'hFF, 0);
  endtask

  task automatic random_flag_items();
    for (int i = 0; i < 24; i++) begin
      run_item({`ALU_CLASS, 4'($random(seed))}, 8'($random(seed)), 8'($random(seed)),
               $random(seed) & 3);
    end
  endtask

  task automatic reject_non_alu();
    // Move words first and then other foreign classes.
    run_item(8'h12, 8'h34, 8'h56, 0);
    run_item(8'h3F, 8'hFF, 8'h01, 0);
    run_item(8'h5A, 8'h80, 8'h80, 1);
    run_item(8'h90, 8'hFF, 8'h01, 0);
    run_item(8'hC6, 8'h81, 8'h00, 0);
  endtask

  task automatic drain_under_backpressure();
    logic [7:0] words [5];
    logic [7:0] ops_b [5];
    logic [7:0] ops_c [5];
    words = '{8'h80, 8'h8E, 8'h44, 8'h81, 8'h85};
    ops_b = '{8'hF0, 8'h81, 8'h12, 8'hFF, 8'h55};
    ops_c = '{8'h20, 8'h00, 8'h34, 8'h01, 8'hAA};
    fork
      begin
        for (int i = 0; i < 5; i++) send(words[i], ops_b[i], ops_c[i]);
      end
      begin
        // Hold long enough for all three stages to fill.
        repeat (30) next_cycle();
        check(8'(out_req), 8'd1, "out_req while held");
        check(8'(in_ack), 8'd0, "in_ack while pipeline full");
        for (int i = 0; i < 5; i++) receive(0);
      end
    join
    repeat (10) next_cycle();
    check(8'(out_req), 8'd0, "out_req after drain");
  endtask

  initial begin
    clk     = 1'b0;
    reset   = 1'b1;
    in_req  = 1'b0;
    instr   = '0;
    b       = '0;
    c       = '0;
    out_ack = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    check_idle_after_reset();
    run_all_functions();
    random_flag_items();
    reject_non_alu();
    drain_under_backpressure();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire
